// File: run_sim.sh
#!/bin/sh
# Builds the burst mapping bridge testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_burst_map \
    -Mdir obj_dir -o tb_burst_map
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_burst_map > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    exit 0
fi
exit 1

// File: source/burst_gearbox.sv
/* Burst count gearbox.
   Cuts one source burst into aligned sink bursts that never cross a page. */
module burst_gearbox
    import burst_map_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          new_req,
    input  logic [ADDR_WIDTH-1:0]         req_addr,
    input  logic [SOURCE_BURST_WIDTH-1:0] req_burstcount,
    input  logic                          accept_req,
    output logic                          req_complete,
    output logic [ADDR_WIDTH-1:0]         sink_addr,
    output logic [SINK_BURST_WIDTH-1:0]   sink_burstcount
);

    logic [ADDR_WIDTH-1:0]         cur_addr;
    logic [SOURCE_BURST_WIDTH-1:0] remaining;
    logic [SINK_BURST_WIDTH-1:0]   burst_len;

    // Largest power of two that satisfies the count, alignment and page limits.
    // A size that passes implies every smaller power of two passes as well
    always_comb
    begin
        int line_idx;
        int to_page;

        line_idx = int'(cur_addr);
        to_page = PAGE_LINES - (line_idx % PAGE_LINES);
        burst_len = SINK_BURST_WIDTH'(1);
        for (int n = 2; n <= SINK_MAX_LINES; n = n * 2)
        begin
            if ((n <= int'(remaining)) && (n <= to_page) &&
                (!NATURAL_ALIGNMENT || ((line_idx % n) == 0)))
            begin
                burst_len = SINK_BURST_WIDTH'(n);
            end
        end
    end

    assign sink_addr = cur_addr;
    assign sink_burstcount = burst_len;

    // Last piece once the offered burst covers everything left
    assign req_complete = (remaining <= SOURCE_BURST_WIDTH'(burst_len));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cur_addr <= '0;
            remaining <= '0;
        end
        else if (new_req)
        begin
            // A new request replaces whatever piece was accepted in the same cycle
            cur_addr <= req_addr;
            remaining <= req_burstcount;
        end
        else if (accept_req)
        begin
            cur_addr <= cur_addr + ADDR_WIDTH'(burst_len);
            remaining <= remaining - SOURCE_BURST_WIDTH'(burst_len);
        end
    end

endmodule

// File: source/burst_map_pkg.sv
/* Burst mapping bridge shared definitions.
   Bus widths, burst limits, page geometry and responder states. */
package burst_map_pkg;

    // Line address and line data
    localparam int ADDR_WIDTH = 10;
    localparam int DATA_WIDTH = 32;

    // Source bursts carry 1 to 8 lines, sink bursts 1 to 4
    localparam int SOURCE_BURST_WIDTH = 4;
    localparam int SINK_BURST_WIDTH = 3;
    localparam int SINK_MAX_LINES = 1 << (SINK_BURST_WIDTH - 1);

    localparam int USER_WIDTH = 4;

    // User bit that marks a sink burst whose write response must be dropped
    localparam int UFLAG_NO_REPLY = 0;

    // Sink bursts stay inside one page and start at a multiple of their size
    localparam int PAGE_LINES = 16;
    localparam bit NATURAL_ALIGNMENT = 1'b1;

    typedef enum logic [1:0] {
        RESP_IDLE,
        RESP_READ,
        RESP_WRITE
    } resp_state_t;

endpackage

// File: source/burst_map_top.sv
/* Burst mapping bridge top level.
   Plain source ports feed the mapper, which drives the line memory responder. */
module burst_map_top
    import burst_map_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          rd_read,
    input  logic [ADDR_WIDTH-1:0]         rd_address,
    input  logic [SOURCE_BURST_WIDTH-1:0] rd_burstcount,
    input  logic [USER_WIDTH-1:0]         rd_user,
    output logic                          rd_waitrequest,
    output logic [DATA_WIDTH-1:0]         rd_readdata,
    output logic                          rd_readdatavalid,
    input  logic                          wr_write,
    input  logic [ADDR_WIDTH-1:0]         wr_address,
    input  logic [SOURCE_BURST_WIDTH-1:0] wr_burstcount,
    input  logic [DATA_WIDTH-1:0]         wr_writedata,
    input  logic [USER_WIDTH-1:0]         wr_user,
    output logic                          wr_waitrequest,
    output logic                          wr_writeresponsevalid,
    output logic [USER_WIDTH-1:0]         wr_writeresponseuser
);

    mem_rdwr_if src_bus (.clk(clk), .reset_n(reset_n));
    mem_rdwr_if snk_bus (.clk(clk), .reset_n(reset_n));

    // Source side requests
    assign src_bus.rd_read = rd_read;
    assign src_bus.rd_address = rd_address;
    assign src_bus.rd_burstcount = rd_burstcount;
    assign src_bus.rd_user = rd_user;
    assign src_bus.wr_write = wr_write;
    assign src_bus.wr_address = wr_address;
    assign src_bus.wr_burstcount = wr_burstcount;
    assign src_bus.wr_writedata = wr_writedata;
    assign src_bus.wr_user = wr_user;

    // Source side responses
    assign rd_waitrequest = src_bus.rd_waitrequest;
    assign rd_readdata = src_bus.rd_readdata;
    assign rd_readdatavalid = src_bus.rd_readdatavalid;
    assign wr_waitrequest = src_bus.wr_waitrequest;
    assign wr_writeresponsevalid = src_bus.wr_writeresponsevalid;
    assign wr_writeresponseuser = src_bus.wr_writeresponseuser;

    burst_mapper mapper_i (
        .mem_source (src_bus.to_source),
        .mem_sink   (snk_bus.to_sink)
    );

    line_mem_responder responder_i (
        .mem_bus (snk_bus.to_source)
    );

endmodule

// File: source/burst_mapper.sv
/* Burst mapper between a source allowing 8-line bursts and a 4-line sink.
   Injected write bursts are flagged so their responses can be dropped. */
module burst_mapper
    import burst_map_pkg::*;
(
    mem_rdwr_if.to_source mem_source,
    mem_rdwr_if.to_sink   mem_sink
);

    logic clk;
    logic reset_n;

    assign clk = mem_sink.clk;
    assign reset_n = mem_sink.reset_n;

    logic                        rd_complete;
    logic                        rd_next;
    logic [SINK_BURST_WIDTH-1:0] s_rd_burstcount;

    // Take a new source read once the sink has nothing left of the current one
    assign rd_next = !mem_sink.rd_waitrequest && (!mem_sink.rd_read || rd_complete);
    assign mem_source.rd_waitrequest = !rd_next;

    burst_gearbox rd_gearbox (
        .clk             (clk),
        .reset_n         (reset_n),
        .new_req         (rd_next && mem_source.rd_read),
        .req_addr        (mem_source.rd_address),
        .req_burstcount  (mem_source.rd_burstcount),
        .accept_req      (mem_sink.rd_read && !mem_sink.rd_waitrequest),
        .req_complete    (rd_complete),
        .sink_addr       (mem_sink.rd_address),
        .sink_burstcount (s_rd_burstcount)
    );

    assign mem_sink.rd_burstcount = SOURCE_BURST_WIDTH'(s_rd_burstcount);

    always_ff @(posedge clk)
    begin
        if (rd_next)
        begin
            mem_sink.rd_read <= mem_source.rd_read;
            mem_sink.rd_user <= mem_source.rd_user;
        end

        if (!reset_n)
        begin
            mem_sink.rd_read <= 1'b0;
        end
    end

    // Read beats carry no burst information, so they return as they are
    assign mem_source.rd_readdata = mem_sink.rd_readdata;
    assign mem_source.rd_readdatavalid = mem_sink.rd_readdatavalid;
    assign mem_source.rd_readresponseuser = mem_sink.rd_readresponseuser;

    logic                        wr_complete;
    logic                        m_wr_sop;
    logic                        s_wr_sop;
    logic [ADDR_WIDTH-1:0]       s_wr_address;
    logic [SINK_BURST_WIDTH-1:0] s_wr_burstcount;
    logic [USER_WIDTH-1:0]       s_wr_user;

    assign mem_source.wr_waitrequest = mem_sink.wr_waitrequest;

    burst_gearbox wr_gearbox (
        .clk             (clk),
        .reset_n         (reset_n),
        .new_req         (mem_source.wr_write && !mem_sink.wr_waitrequest && m_wr_sop),
        .req_addr        (mem_source.wr_address),
        .req_burstcount  (mem_source.wr_burstcount),
        .accept_req      (mem_sink.wr_write && !mem_sink.wr_waitrequest && s_wr_sop),
        .req_complete    (wr_complete),
        .sink_addr       (s_wr_address),
        .sink_burstcount (s_wr_burstcount)
    );

    // Address and count matter only on the first beat of each sink burst
    assign mem_sink.wr_address = s_wr_sop ? s_wr_address : '0;
    assign mem_sink.wr_burstcount = s_wr_sop ? SOURCE_BURST_WIDTH'(s_wr_burstcount) : '0;

    always_ff @(posedge clk)
    begin
        if (!mem_sink.wr_waitrequest)
        begin
            mem_sink.wr_write <= mem_source.wr_write;
            mem_sink.wr_writedata <= mem_source.wr_writedata;
            if (m_wr_sop)
            begin
                s_wr_user <= mem_source.wr_user;
            end
        end

        if (!reset_n)
        begin
            mem_sink.wr_write <= 1'b0;
        end
    end

    // Only the last sink burst of a source burst may produce a response
    always_comb
    begin
        mem_sink.wr_user = s_wr_user;
        mem_sink.wr_user[UFLAG_NO_REPLY] = !(wr_complete && s_wr_sop);
    end

    sop_tracker m_sop_tracker (
        .clk        (clk),
        .reset_n    (reset_n),
        .flit_valid (mem_source.wr_write && !mem_source.wr_waitrequest),
        .burstcount (mem_source.wr_burstcount),
        .sop        (m_wr_sop)
    );

    sop_tracker s_sop_tracker (
        .clk        (clk),
        .reset_n    (reset_n),
        .flit_valid (mem_sink.wr_write && !mem_sink.wr_waitrequest),
        .burstcount (SOURCE_BURST_WIDTH'(s_wr_burstcount)),
        .sop        (s_wr_sop)
    );

    assign mem_source.wr_writeresponsevalid =
        mem_sink.wr_writeresponsevalid && !mem_sink.wr_writeresponseuser[UFLAG_NO_REPLY];
    assign mem_source.wr_writeresponseuser = mem_sink.wr_writeresponseuser;

endmodule

// File: source/line_mem_responder.sv
/* Line memory acting as the bus sink.
   Serves one read or write burst at a time and acknowledges each write burst. */
module line_mem_responder
    import burst_map_pkg::*;
(
    mem_rdwr_if.to_source mem_bus
);

    logic clk;
    logic reset_n;

    assign clk = mem_bus.clk;
    assign reset_n = mem_bus.reset_n;

    logic [DATA_WIDTH-1:0]         mem [0:(1 << ADDR_WIDTH)-1];
    resp_state_t                   state;
    logic [ADDR_WIDTH-1:0]         cur_addr;
    logic [SOURCE_BURST_WIDTH-1:0] beats_left;
    logic [USER_WIDTH-1:0]         wr_user_q;

    logic                  rd_accept;
    logic                  wr_accept;
    logic                  wr_first;
    logic                  wr_last;
    logic [ADDR_WIDTH-1:0] rd_line;
    logic [ADDR_WIDTH-1:0] wr_line;

    // Reads win over writes when both arrive in idle
    assign mem_bus.rd_waitrequest = (state != RESP_IDLE);
    assign mem_bus.wr_waitrequest = (state == RESP_READ) ||
                                    ((state == RESP_IDLE) && mem_bus.rd_read);

    assign rd_accept = (state == RESP_IDLE) && mem_bus.rd_read;
    assign wr_accept = mem_bus.wr_write && !mem_bus.wr_waitrequest;
    assign wr_first = (state == RESP_IDLE);
    assign rd_line = rd_accept ? mem_bus.rd_address : cur_addr;
    assign wr_line = wr_first ? mem_bus.wr_address : cur_addr;
    assign wr_last = wr_first ? (mem_bus.wr_burstcount == SOURCE_BURST_WIDTH'(1))
                              : (beats_left == SOURCE_BURST_WIDTH'(1));

    always_ff @(posedge clk)
    begin
        if (wr_accept)
        begin
            mem[wr_line] <= mem_bus.wr_writedata;
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            RESP_IDLE:
            begin
                if (mem_bus.rd_read)
                begin
                    cur_addr <= mem_bus.rd_address + 1'b1;
                    beats_left <= mem_bus.rd_burstcount - 1'b1;
                    mem_bus.rd_readresponseuser <= mem_bus.rd_user;
                    if (mem_bus.rd_burstcount != SOURCE_BURST_WIDTH'(1))
                    begin
                        state <= RESP_READ;
                    end
                end
                else if (mem_bus.wr_write)
                begin
                    cur_addr <= mem_bus.wr_address + 1'b1;
                    beats_left <= mem_bus.wr_burstcount - 1'b1;
                    wr_user_q <= mem_bus.wr_user;
                    if (!wr_last)
                    begin
                        state <= RESP_WRITE;
                    end
                end
            end
            RESP_READ:
            begin
                cur_addr <= cur_addr + 1'b1;
                beats_left <= beats_left - 1'b1;
                if (beats_left == SOURCE_BURST_WIDTH'(1))
                begin
                    state <= RESP_IDLE;
                end
            end
            RESP_WRITE:
            begin
                if (mem_bus.wr_write)
                begin
                    cur_addr <= cur_addr + 1'b1;
                    beats_left <= beats_left - 1'b1;
                    if (wr_last)
                    begin
                        state <= RESP_IDLE;
                    end
                end
            end
            default:
            begin
                state <= RESP_IDLE;
            end
        endcase

        // Beat k of a read appears k+1 cycles after the burst was accepted
        mem_bus.rd_readdata <= mem[rd_line];
        mem_bus.rd_readdatavalid <= rd_accept || (state == RESP_READ);

        mem_bus.wr_writeresponsevalid <= wr_accept && wr_last;
        if (wr_accept && wr_last)
        begin
            mem_bus.wr_writeresponseuser <= wr_first ? mem_bus.wr_user : wr_user_q;
        end

        if (!reset_n)
        begin
            state <= RESP_IDLE;
            cur_addr <= '0;
            beats_left <= '0;
            mem_bus.rd_readdatavalid <= 1'b0;
            mem_bus.wr_writeresponsevalid <= 1'b0;
        end
    end

endmodule

// File: source/mem_rdwr_if.sv
/* Split read/write memory bus with burst counts.
   One read channel and one write channel sharing a clock and reset. */
interface mem_rdwr_if
    import burst_map_pkg::*;
(
    input logic clk,
    input logic reset_n
);

    // Read channel
    logic                          rd_read;
    logic                          rd_waitrequest;
    logic [ADDR_WIDTH-1:0]         rd_address;
    logic [SOURCE_BURST_WIDTH-1:0] rd_burstcount;
    logic [USER_WIDTH-1:0]         rd_user;
    logic [DATA_WIDTH-1:0]         rd_readdata;
    logic                          rd_readdatavalid;
    logic [USER_WIDTH-1:0]         rd_readresponseuser;

    // Write channel
    logic                          wr_write;
    logic                          wr_waitrequest;
    logic [ADDR_WIDTH-1:0]         wr_address;
    logic [SOURCE_BURST_WIDTH-1:0] wr_burstcount;
    logic [DATA_WIDTH-1:0]         wr_writedata;
    logic [USER_WIDTH-1:0]         wr_user;
    logic                          wr_writeresponsevalid;
    logic [USER_WIDTH-1:0]         wr_writeresponseuser;

    // Side that answers requests
    modport to_source (
        input  clk, reset_n,
        input  rd_read, rd_address, rd_burstcount, rd_user,
        output rd_waitrequest, rd_readdata, rd_readdatavalid, rd_readresponseuser,
        input  wr_write, wr_address, wr_burstcount, wr_writedata, wr_user,
        output wr_waitrequest, wr_writeresponsevalid, wr_writeresponseuser
    );

    // Side that issues requests
    modport to_sink (
        input  clk, reset_n,
        output rd_read, rd_address, rd_burstcount, rd_user,
        input  rd_waitrequest, rd_readdata, rd_readdatavalid, rd_readresponseuser,
        output wr_write, wr_address, wr_burstcount, wr_writedata, wr_user,
        input  wr_waitrequest, wr_writeresponsevalid, wr_writeresponseuser
    );

endinterface

// File: source/sop_tracker.sv
/* Start-of-packet tracker for write bursts. */
module sop_tracker
    import burst_map_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          flit_valid,
    input  logic [SOURCE_BURST_WIDTH-1:0] burstcount,
    output logic                          sop
);

    // Beats still expected after the current one
    logic [SOURCE_BURST_WIDTH-1:0] beats_left;

    assign sop = (beats_left == '0);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            beats_left <= '0;
        end
        else if (flit_valid)
        begin
            // The burst count is only meaningful on the first beat
            beats_left <= sop ? (burstcount - 1'b1) : (beats_left - 1'b1);
        end
    end

endmodule

// File: src.f
source/burst_map_pkg.sv
source/mem_rdwr_if.sv
source/sop_tracker.sv
source/burst_gearbox.sv
source/burst_mapper.sv
source/line_mem_responder.sv
source/burst_map_top.sv
testbench/tb_burst_map.sv

// File: testbench/tb_burst_map.sv
/* Burst mapping bridge testbench.
   Random read and write bursts checked against a line memory model. */
module tb_burst_map
    import burst_map_pkg::*;
();

    localparam int MEM_LINES = 1 << ADDR_WIDTH;
    localparam int RANDOM_OPS = 300;
    localparam int DIRECTED_OPS = 6;
    localparam int CYCLES_PER_OP = 40;
    localparam int RESET_CYCLES = 16;
    localparam int SETTLE_CYCLES = 4;
    // Filling the memory takes at most one write per line
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + (MEM_LINES + 2 * RANDOM_OPS + DIRECTED_OPS) * CYCLES_PER_OP;

    logic                          clk;
    logic                          reset_n;
    logic                          rd_read;
    logic [ADDR_WIDTH-1:0]         rd_address;
    logic [SOURCE_BURST_WIDTH-1:0] rd_burstcount;
    logic [USER_WIDTH-1:0]         rd_user;
    logic                          rd_waitrequest;
    logic [DATA_WIDTH-1:0]         rd_readdata;
    logic                          rd_readdatavalid;
    logic                          wr_write;
    logic [ADDR_WIDTH-1:0]         wr_address;
    logic [SOURCE_BURST_WIDTH-1:0] wr_burstcount;
    logic [DATA_WIDTH-1:0]         wr_writedata;
    logic [USER_WIDTH-1:0]         wr_user;
    logic                          wr_waitrequest;
    logic                          wr_writeresponsevalid;
    logic [USER_WIDTH-1:0]         wr_writeresponseuser;

    logic [DATA_WIDTH-1:0] model [0:MEM_LINES-1];
    logic [DATA_WIDTH-1:0] rd_q [$];
    logic [USER_WIDTH-1:0] resp_user;
    int                    resp_count;
    int                    writes_done;
    int                    rd_errors;
    int                    wr_errors;
    int                    idle_errors;

    burst_map_top dut_i (
        .clk                   (clk),
        .reset_n               (reset_n),
        .rd_read               (rd_read),
        .rd_address            (rd_address),
        .rd_burstcount         (rd_burstcount),
        .rd_user               (rd_user),
        .rd_waitrequest        (rd_waitrequest),
        .rd_readdata           (rd_readdata),
        .rd_readdatavalid      (rd_readdatavalid),
        .wr_write              (wr_write),
        .wr_address            (wr_address),
        .wr_burstcount         (wr_burstcount),
        .wr_writedata          (wr_writedata),
        .wr_user               (wr_user),
        .wr_waitrequest        (wr_waitrequest),
        .wr_writeresponsevalid (wr_writeresponsevalid),
        .wr_writeresponseuser  (wr_writeresponseuser)
    );

    always #2 clk = ~clk;

    // Outputs are sampled mid-cycle, away from the edge that drives inputs
    always @(negedge clk)
    begin
        if (reset_n && rd_readdatavalid)
        begin
            rd_q.push_back(rd_readdata);
        end
        if (reset_n && wr_writeresponsevalid)
        begin
            resp_count = resp_count + 1;
            resp_user = wr_writeresponseuser;
        end
    end

    task automatic settle();
        repeat (SETTLE_CYCLES) @(posedge clk);
    endtask

    // Returns on the edge where the request is taken
    task automatic wait_accept(input logic is_write);
        logic acc;

        acc = 1'b0;
        while (!acc)
        begin
            @(negedge clk);
            acc = is_write ? !wr_waitrequest : !rd_waitrequest;
            @(posedge clk);
        end
    endtask

    // Nothing may come back while no operation is outstanding
    task automatic check_idle();
        assert (rd_q.size() == 0) else
        begin
            idle_errors++;
            $display("FAIL %0t: %0d read beats arrived with no read outstanding",
                     $time, rd_q.size());
        end
        assert (resp_count == writes_done) else
        begin
            idle_errors++;
            $display("FAIL %0t: %0d write responses seen for %0d write bursts",
                     $time, resp_count, writes_done);
        end
    endtask

    task automatic write_burst(input logic [ADDR_WIDTH-1:0] addr, input int cnt);
        logic [USER_WIDTH-1:0] user;
        logic [DATA_WIDTH-1:0] data;
        int                    resp_before;

        check_idle();
        user = USER_WIDTH'($urandom);
        user[UFLAG_NO_REPLY] = 1'b0;
        resp_before = resp_count;
        @(posedge clk);
        wr_address <= addr;
        wr_burstcount <= SOURCE_BURST_WIDTH'(cnt);
        wr_user <= user;
        for (int k = 0; k < cnt; k++)
        begin
            data = $urandom;
            wr_write <= 1'b1;
            wr_writedata <= data;
            wait_accept(1'b1);
            model[addr + ADDR_WIDTH'(k)] = data;
        end
        wr_write <= 1'b0;
        while (resp_count == resp_before)
        begin
            @(posedge clk);
        end
        settle();
        // Injected sink bursts must not add responses of their own
        assert (resp_count == resp_before + 1) else
        begin
            wr_errors++;
            $display("FAIL %0t: write at %0d count %0d gave %0d responses, expected 1",
                     $time, addr, cnt, resp_count - resp_before);
        end
        assert (resp_user[USER_WIDTH-1:1] == user[USER_WIDTH-1:1]) else
        begin
            wr_errors++;
            $display("FAIL %0t: response user %h, expected %h", $time, resp_user, user);
        end
        writes_done++;
    endtask

    task automatic read_burst(input logic [ADDR_WIDTH-1:0] addr, input int cnt);
        logic [USER_WIDTH-1:0] user;

        check_idle();
        user = USER_WIDTH'($urandom);
        user[UFLAG_NO_REPLY] = 1'b0;
        @(posedge clk);
        rd_read <= 1'b1;
        rd_address <= addr;
        rd_burstcount <= SOURCE_BURST_WIDTH'(cnt);
        rd_user <= user;
        wait_accept(1'b0);
        rd_read <= 1'b0;
        while (rd_q.size() < cnt)
        begin
            @(posedge clk);
        end
        settle();
        assert (rd_q.size() == cnt) else
        begin
            rd_errors++;
            $display("FAIL %0t: read at %0d returned %0d beats, expected %0d",
                     $time, addr, rd_q.size(), cnt);
        end
        for (int k = 0; k < cnt; k++)
        begin
            assert (rd_q[k] === model[addr + ADDR_WIDTH'(k)]) else
            begin
                rd_errors++;
                $display("FAIL %0t: read at %0d beat %0d got %h, expected %h",
                         $time, addr, k, rd_q[k], model[addr + ADDR_WIDTH'(k)]);
            end
        end
        rd_q.delete();
    endtask

    task automatic fill_memory();
        int line;
        int cnt;

        line = 0;
        while (line < MEM_LINES)
        begin
            cnt = 1 + int'($urandom % 8);
            if (cnt > MEM_LINES - line)
            begin
                cnt = MEM_LINES - line;
            end
            write_burst(ADDR_WIDTH'(line), cnt);
            line += cnt;
        end
    endtask

    initial
    begin
        logic [ADDR_WIDTH-1:0] addr;
        int                    cnt;

        void'($urandom(32'h3749_678c));
        clk = 1'b0;
        reset_n = 1'b0;
        rd_read = 1'b0;
        rd_address = '0;
        rd_burstcount = '0;
        rd_user = '0;
        wr_write = 1'b0;
        wr_address = '0;
        wr_burstcount = '0;
        wr_writedata = '0;
        wr_user = '0;
        resp_user = '0;
        resp_count = 0;
        writes_done = 0;
        rd_errors = 0;
        wr_errors = 0;
        idle_errors = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;

        repeat (8)
        begin
            @(negedge clk);
            assert (rd_readdatavalid === 1'b0 && wr_writeresponsevalid === 1'b0) else
            begin
                idle_errors++;
                $display("FAIL %0t: valid output high after reset with no request", $time);
            end
        end

        fill_memory();

        // Unaligned, page crossing and address wrapping bursts
        write_burst(10'd13, 8);
        read_burst(10'd13, 8);
        write_burst(10'd1019, 8);
        read_burst(10'd1019, 8);
        write_burst(10'd6, 6);
        read_burst(10'd6, 6);

        for (int i = 0; i < RANDOM_OPS; i++)
        begin
            addr = ADDR_WIDTH'($urandom);
            cnt = 1 + int'($urandom % 8);
            case ($urandom % 3)
                0: read_burst(addr, cnt);
                1: write_burst(addr, cnt);
                default:
                begin
                    write_burst(addr, cnt);
                    read_burst(addr, cnt);
                end
            endcase
        end

        settle();
        check_idle();
        $display("Error counts: read %0d, write %0d, idle %0d",
                 rd_errors, wr_errors, idle_errors);
        if (rd_errors + wr_errors + idle_errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the DUT stopped answering within %0d cycles", WATCHDOG_CYCLES);
        $display("Error counts: read %0d, write %0d, idle %0d",
                 rd_errors, wr_errors, idle_errors);
        $display("Errors found");
        $finish;
    end

endmodule
